// File: verilog/t11_params.svh
// Build-time constants for the T-11 bus demo.
// Changing T11_MEM_AW also changes how many address bits the memory decodes.
// The byte address is 8 bits, so T11_MEM_AW must stay at 7 or below.
`ifndef T11_PARAMS_SVH
`define T11_PARAMS_SVH

// Memory wait states, counted from CAS falling to READY rising
`define T11_WAIT_STATES 2

// Released-button cycles needed before system reset ends
`define T11_RESET_HOLD 255

// Word address width of the bus memory (128 words)
`define T11_MEM_AW 7

// Vector of request line 0, octal 100
`define T11_VEC_BASE 16'o100

`endif

// File: verilog/t11_bus_pkg.sv
// Types of the multiplexed T-11 style external bus.
// Strobes are active low, as on the real chip.
// Only the memory and interrupt-acknowledge select codes are decoded.
package t11_bus_pkg;

   typedef logic [15:0] dal_t;     // Data/address lines
   typedef logic [7:0]  addr_t;    // Byte address
   typedef logic [1:0]  wb_t;      // Active-low write/byte mask
   typedef logic [1:0]  sel_t;     // Cycle select code

   // Select codes
   localparam sel_t SEL_MEM  = 2'b00;   // Memory cycle
   localparam sel_t SEL_IACK = 2'b11;   // Interrupt acknowledge

   // Both mask bits high means no write
   localparam wb_t WB_READ = 2'b11;

   // Sequencer states
   typedef enum logic [1:0]
   {
      IDLE,    // No cycle
      ADDR,    // RAS low, address on DAL
      DATA,    // CAS low, wait for READY
      DONE     // Strobes released, result valid
   } bus_state_t;

endpackage

// File: verilog/board_pkg.sv
// Types of the DE0 board side: display patterns and the switch console.
// Segment patterns are active low with the decimal point at bit 7.
package board_pkg;

   typedef logic [7:0] seg_t;      // Active-low segments, dp at bit 7
   typedef logic [3:0] nibble_t;   // One hex digit

   // Console op, taken from switches 9:8
   typedef enum logic [1:0]
   {
      LOAD       = 2'b00,   // Load address register
      WRITE_BYTE = 2'b01,   // Byte write to addr
      READ       = 2'b10,   // Word read from addr
      IACK       = 2'b11    // Interrupt acknowledge read
   } op_t;

   // Console states
   typedef enum logic
   {
      CON_IDLE,   // Ready for a button press
      WAIT_BUS    // Bus cycle in flight
   } console_state_t;

endpackage

// File: verilog/reset_gen.sv
// Reset stretcher for the board push button.
// System reset holds for T11_RESET_HOLD + 1 clean cycles after release.
// Any low sample of the button restarts the hold count.
`timescale 1ns/1ns
`include "t11_params.svh"

module reset_gen
(
   input  logic clk,
   input  logic rst_n,        // Raw push button, active low
   output logic sys_rst_n     // Stretched system reset
);

   localparam int CW = $clog2(`T11_RESET_HOLD + 1);

   logic [CW-1:0] cnt;        // Clean released cycles

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         cnt <= '0;                           // Bounce restarts count
      else if (cnt != CW'(`T11_RESET_HOLD))
         cnt <= cnt + 1'b1;                   // Saturates at hold

      // Registered terminal compare
      sys_rst_n <= rst_n && (cnt == CW'(`T11_RESET_HOLD));
   end

endmodule

// File: verilog/switch_console.sv
// Switch console that stands in for the processor.
// Buttons are active low and pass a two-stage synchronizer before edge detection.
// Execute presses are dropped while a bus cycle is running.
`timescale 1ns/1ns

module switch_console
(
   input  logic               clk,
   input  logic               sys_rst_n,
   input  logic [1:0]         button,     // 0 execute, 1 step address
   input  logic [9:0]         sw,         // 9:8 op, 7:0 value
   input  logic               busy,
   output logic               start,      // One-cycle bus request
   output board_pkg::op_t     op,
   output t11_bus_pkg::addr_t addr,
   output t11_bus_pkg::dal_t  wdata
);

   import board_pkg::*;

   logic [1:0]     sync1;      // First sync stage
   logic [1:0]     sync2;      // Second sync stage
   logic [1:0]     btn_q;      // Previous synced level
   logic           exec_p;     // Execute press pulse
   logic           step_p;     // Step press pulse
   console_state_t state;
   op_t            sw_op;

   assign sw_op = op_t'(sw[9:8]);

   // Synchronizer and falling-edge detect
   always_ff @(posedge clk)
   begin
      if (!sys_rst_n)
      begin
         sync1  <= 2'b11;     // Released
         sync2  <= 2'b11;
         btn_q  <= 2'b11;
         exec_p <= 1'b0;
         step_p <= 1'b0;
      end
      else
      begin
         sync1  <= button;
         sync2  <= sync1;
         btn_q  <= sync2;
         exec_p <= btn_q[0] & ~sync2[0];   // High-to-low seen
         step_p <= btn_q[1] & ~sync2[1];
      end
   end

   always_ff @(posedge clk)
   begin
      if (!sys_rst_n)
      begin
         state <= CON_IDLE;
         start <= 1'b0;
         op    <= LOAD;
         addr  <= '0;
      end
      else
      begin
         start <= 1'b0;                    // Pulse only
         case (state)
            CON_IDLE:
               if (exec_p && !busy)
               begin
                  if (sw_op == LOAD)
                     addr <= sw[7:0];      // No bus cycle
                  else
                  begin
                     start <= 1'b1;
                     op    <= sw_op;
                     state <= WAIT_BUS;
                  end
               end
            WAIT_BUS:
               // Start still high means busy has not risen yet
               if (!busy && !start)
                  state <= CON_IDLE;
            default:
               state <= CON_IDLE;
         endcase
         if (step_p)
            addr <= addr + 8'd2;           // Next word
      end
   end

   // Same byte on both lanes, the mask picks one
   always_ff @(posedge clk)
   begin
      if (state == CON_IDLE && exec_p && !busy)
         wdata <= {2{sw[7:0]}};
   end

endmodule

// File: verilog/bus_cycle.sv
// T-11 style bus cycle sequencer.
// One cycle of RAS with the address, then CAS until READY, then one idle-strobe cycle.
// Request inputs are latched on start, so the console may change them mid-cycle.
// The byte lane of a write comes from address bit 0.
`timescale 1ns/1ns

module bus_cycle
(
   input  logic               clk,
   input  logic               sys_rst_n,
   input  logic               start,
   input  board_pkg::op_t     op,
   input  t11_bus_pkg::addr_t addr,
   input  t11_bus_pkg::dal_t  wdata,
   input  logic               ready,
   input  t11_bus_pkg::dal_t  rdata_bus,  // Word returned by target
   output logic               ras_n,
   output logic               cas_n,
   output logic               pi,         // Priority strobe on IACK
   output t11_bus_pkg::sel_t  sel,
   output t11_bus_pkg::wb_t   wb_n,
   output t11_bus_pkg::dal_t  dal_out,
   output logic               busy,
   output logic               done,
   output t11_bus_pkg::dal_t  rdata
);

   import t11_bus_pkg::*;
   import board_pkg::*;

   bus_state_t state;
   op_t        op_q;        // Latched request
   addr_t      addr_q;
   dal_t       wdata_q;
   logic       is_write;
   logic       is_iack;

   assign is_write = (op_q == WRITE_BYTE);
   assign is_iack  = (op_q == IACK);

   always_ff @(posedge clk)
   begin
      if (!sys_rst_n)
      begin
         state <= IDLE;
         op_q  <= READ;
      end
      else
      begin
         case (state)
            IDLE:
               if (start)
               begin
                  state <= ADDR;
                  op_q  <= op;
               end
            ADDR:    state <= DATA;            // Single address cycle
            DATA:    if (ready) state <= DONE; // Target wait states
            DONE:    state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == IDLE && start)
      begin
         addr_q  <= addr;
         wdata_q <= wdata;
      end
      if (state == DATA && ready && !is_write)
         rdata <= rdata_bus;                  // Valid from DONE on
   end

   assign busy  = (state != IDLE);
   assign done  = (state == DONE);
   assign ras_n = !(state == ADDR || state == DATA);
   assign cas_n = (state != DATA);
   assign pi    = (state == DONE) && is_iack; // Clears acked line
   assign sel   = (busy && is_iack) ? SEL_IACK : SEL_MEM;

   // Odd address writes the high lane
   assign wb_n = (state == DATA && is_write) ? (addr_q[0] ? 2'b01 : 2'b10) : WB_READ;

   always_comb
   begin
      case (state)
         ADDR:    dal_out = dal_t'(addr_q);            // Address phase
         DATA:    dal_out = is_write ? wdata_q : '0;   // Write data
         default: dal_out = '0;
      endcase
   end

endmodule

// File: verilog/bus_memory.sv
// Word memory on the T-11 bus with byte-lane writes.
// Answers only select code 00. READY comes T11_WAIT_STATES cycles after CAS falls.
// Contents are not cleared by reset.
`timescale 1ns/1ns
`include "t11_params.svh"

module bus_memory
#(
   parameter int AW = `T11_MEM_AW        // Word address width
)
(
   input  logic              clk,
   input  logic              ras_n,
   input  logic              cas_n,
   input  t11_bus_pkg::sel_t sel,
   input  t11_bus_pkg::wb_t  wb_n,
   input  t11_bus_pkg::dal_t dal_out,
   output logic              ready,
   output t11_bus_pkg::dal_t rdata
);

   import t11_bus_pkg::*;

   localparam int WW = $clog2(`T11_WAIT_STATES + 2);

   dal_t          mem [2**AW];   // Word storage
   logic [AW-1:0] waddr;         // Word address from RAS
   logic          ras_q;         // RAS of last cycle
   logic [WW-1:0] wcnt;          // Wait states elapsed
   logic          cycle_on;      // CAS low on a memory cycle

   assign cycle_on = !cas_n && (sel == SEL_MEM);
   assign ready    = cycle_on && (wcnt == WW'(`T11_WAIT_STATES));
   assign rdata    = mem[waddr];  // Whole word, both lanes

   always_ff @(posedge clk)
   begin
      ras_q <= ras_n;
      if (ras_q && !ras_n)
         waddr <= dal_out[AW:1];  // Falling RAS, drop byte bit

      if (!cycle_on)
         wcnt <= '0;              // Restart when CAS rises
      else if (wcnt != WW'(`T11_WAIT_STATES))
         wcnt <= wcnt + 1'b1;
   end

   // Lane writes on the READY cycle only
   always_ff @(posedge clk)
   begin
      if (ready && !wb_n[0])
         mem[waddr][7:0] <= dal_out[7:0];
      if (ready && !wb_n[1])
         mem[waddr][15:8] <= dal_out[15:8];
   end

endmodule

// File: verilog/intr_encoder.sv
// Coded interrupt priority encoder, line 3 highest.
// Request lines are async, sampled once and latched on their rising edge.
// An acknowledge cycle returns T11_VEC_BASE + 4 * line and PI clears that line.
`timescale 1ns/1ns
`include "t11_params.svh"

module intr_encoder
(
   input  logic              clk,
   input  logic              sys_rst_n,
   input  logic [3:0]        irq,       // Active high requests
   input  logic              cas_n,
   input  t11_bus_pkg::sel_t sel,
   input  logic              pi,
   output logic [3:0]        cp_n,      // Inverted code, index + 1
   output logic              vec_n,     // Low while any pending
   output logic              ready,
   output t11_bus_pkg::dal_t vector
);

   import t11_bus_pkg::*;

   logic [3:0] irq_s;     // Sampled lines
   logic [3:0] irq_q;     // Previous sample
   logic [3:0] pend;      // Latched requests
   logic [1:0] idx;       // Winning line

   // Later lines overwrite, so highest wins
   always_comb
   begin
      idx = 2'd0;
      for (int i = 0; i < 4; i++)
         if (pend[i])
            idx = 2'(i);
   end

   assign vec_n  = ~|pend;
   assign cp_n   = vec_n ? 4'hF : ~(4'(idx) + 4'd1);
   assign vector = dal_t'(`T11_VEC_BASE) + dal_t'({idx, 2'b00});
   assign ready  = !cas_n && (sel == SEL_IACK);   // No wait states

   always_ff @(posedge clk)
   begin
      if (!sys_rst_n)
      begin
         irq_s <= '0;
         irq_q <= '0;
         pend  <= '0;
      end
      else
      begin
         irq_s <= irq;
         irq_q <= irq_s;
         pend  <= (pend & ~(pi ? (4'b0001 << idx) : 4'b0000)) | (irq_s & ~irq_q);
      end
   end

endmodule

// File: verilog/hex_display.sv
// Four-digit display of the last word read on the bus.
// Segments are active low, decimal points stay off. Digit 0 is the low nibble.
`timescale 1ns/1ns

module hex_display
(
   input  logic              clk,
   input  logic              sys_rst_n,
   input  logic              done,
   input  t11_bus_pkg::dal_t rdata,
   output board_pkg::seg_t   hex0,
   output board_pkg::seg_t   hex1,
   output board_pkg::seg_t   hex2,
   output board_pkg::seg_t   hex3
);

   import t11_bus_pkg::*;
   import board_pkg::*;

   dal_t shown;     // Word on the digits

   // Common-anode font, dp bit high
   function automatic seg_t seg_of(input nibble_t n);
      case (n)
         4'h0:    seg_of = 8'hC0;
         4'h1:    seg_of = 8'hF9;
         4'h2:    seg_of = 8'hA4;
         4'h3:    seg_of = 8'hB0;
         4'h4:    seg_of = 8'h99;
         4'h5:    seg_of = 8'h92;
         4'h6:    seg_of = 8'h82;
         4'h7:    seg_of = 8'hF8;
         4'h8:    seg_of = 8'h80;
         4'h9:    seg_of = 8'h90;
         4'hA:    seg_of = 8'h88;
         4'hB:    seg_of = 8'h83;
         4'hC:    seg_of = 8'hC6;
         4'hD:    seg_of = 8'hA1;
         4'hE:    seg_of = 8'h86;
         default: seg_of = 8'h8E;   // F
      endcase
   endfunction

   always_ff @(posedge clk)
   begin
      if (!sys_rst_n)
         shown <= '0;          // Shows 0000
      else if (done)
         shown <= rdata;
   end

   assign hex0 = seg_of(shown[3:0]);
   assign hex1 = seg_of(shown[7:4]);
   assign hex2 = seg_of(shown[11:8]);
   assign hex3 = seg_of(shown[15:12]);

endmodule

// File: verilog/de0.sv
// DE0 board top for the T-11 bus demo.
// A switch console replaces the processor. SDRAM, flash, LCD, SD, PS2, VGA and UART
// pins are not carried. The bus goes out on GPIO0 and the DAL on the SDRAM data
// pins, both as output-only probes for a logic analyzer.
`timescale 1ns/1ns

module de0
(
   input  logic              clk,            // 50 MHz
   input  logic              rst_n,          // Reset button
   input  logic [1:0]        de0_button,     // Execute, step
   input  logic [9:0]        de0_sw,
   input  logic [3:0]        de0_gpio1_d,    // Interrupt requests
   output board_pkg::seg_t   de0_hex0,
   output board_pkg::seg_t   de0_hex1,
   output board_pkg::seg_t   de0_hex2,
   output board_pkg::seg_t   de0_hex3,
   output logic [9:0]        de0_led,
   output logic [31:0]       de0_gpio0_d,    // Bus probe
   output t11_bus_pkg::dal_t de0_dram_dq     // DAL probe
);

   import t11_bus_pkg::*;
   import board_pkg::*;

   logic       sys_rst_n;
   logic       start;
   logic       busy;
   logic       done;
   logic       ras_n;
   logic       cas_n;
   logic       pi;
   logic       ready;        // Selected target READY
   logic       mem_ready;
   logic       irq_ready;
   logic       vec_n;
   logic [3:0] cp_n;
   op_t        op;
   addr_t      addr;
   sel_t       sel;
   wb_t        wb_n;
   dal_t       wdata;
   dal_t       dal_out;
   dal_t       rdata;        // Captured read word
   dal_t       rdata_bus;    // Selected target word
   dal_t       mem_rdata;
   dal_t       vector;

   reset_gen u_reset (.clk(clk), .rst_n(rst_n), .sys_rst_n(sys_rst_n));

   switch_console u_console
   (
      .clk(clk), .sys_rst_n(sys_rst_n), .button(de0_button), .sw(de0_sw),
      .busy(busy), .start(start), .op(op), .addr(addr), .wdata(wdata)
   );

   bus_cycle u_bus
   (
      .clk(clk), .sys_rst_n(sys_rst_n), .start(start), .op(op), .addr(addr),
      .wdata(wdata), .ready(ready), .rdata_bus(rdata_bus), .ras_n(ras_n),
      .cas_n(cas_n), .pi(pi), .sel(sel), .wb_n(wb_n), .dal_out(dal_out),
      .busy(busy), .done(done), .rdata(rdata)
   );

   bus_memory u_mem
   (
      .clk(clk), .ras_n(ras_n), .cas_n(cas_n), .sel(sel), .wb_n(wb_n),
      .dal_out(dal_out), .ready(mem_ready), .rdata(mem_rdata)
   );

   intr_encoder u_intr
   (
      .clk(clk), .sys_rst_n(sys_rst_n), .irq(de0_gpio1_d), .cas_n(cas_n),
      .sel(sel), .pi(pi), .cp_n(cp_n), .vec_n(vec_n), .ready(irq_ready),
      .vector(vector)
   );

   hex_display u_hex
   (
      .clk(clk), .sys_rst_n(sys_rst_n), .done(done), .rdata(rdata),
      .hex0(de0_hex0), .hex1(de0_hex1), .hex2(de0_hex2), .hex3(de0_hex3)
   );

   // Target select by cycle code
   assign rdata_bus = (sel == SEL_IACK) ? vector : mem_rdata;
   assign ready     = (sel == SEL_IACK) ? irq_ready : mem_ready;

   // Probe layout for the analyzer pod
   assign de0_gpio0_d = {19'd0, vec_n, cp_n, ready, wb_n, sel, pi, cas_n, ras_n};
   assign de0_dram_dq = dal_out;

   assign de0_led = {6'd0, ~rst_n, ~sys_rst_n, ~vec_n, busy};

endmodule

// File: sim/tb_de0.sv
// Directed testbench for the DE0 T-11 bus demo top.
// Inputs change on the falling clock edge and outputs are sampled there too.
// Memory words are only read back after both of their bytes have been written.
`timescale 1ns/1ns
`include "t11_params.svh"

module tb_de0;

   import t11_bus_pkg::*;
   import board_pkg::*;

   logic       clk;
   logic       rst_n;
   logic [1:0] button;
   logic [9:0] sw;
   logic [3:0] irq;
   seg_t       hex0;
   seg_t       hex1;
   seg_t       hex2;
   seg_t       hex3;
   logic [9:0] led;
   logic [31:0] gpio0;
   dal_t       dram_dq;

   int         errors = 0;
   logic [15:0] lfsr = 16'd38;        // Stimulus LFSR state
   addr_t      a2;                    // Word address used by several tests
   dal_t       model [2**`T11_MEM_AW];   // Expected memory contents

   // Active-low 0-F font, dp off
   seg_t font [16] = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
                       8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E};

   de0 DUT
   (
      .clk(clk), .rst_n(rst_n), .de0_button(button), .de0_sw(sw), .de0_gpio1_d(irq),
      .de0_hex0(hex0), .de0_hex1(hex1), .de0_hex2(hex2), .de0_hex3(hex3),
      .de0_led(led), .de0_gpio0_d(gpio0), .de0_dram_dq(dram_dq)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;         // 20 ns period
   end

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic lfsr_bit();
      logic fb;
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      return fb;
   endfunction

   function automatic logic [7:0] random_byte();
      logic [7:0] v;
      v = '0;
      for (int i = 0; i < 8; i++)
         v = {v[6:0], lfsr_bit()};    // One step per bit
      return v;
   endfunction

   // Digit pattern back to its nibble, x if not in the font
   function automatic nibble_t digit_value(input seg_t s);
      nibble_t n;
      n = 'x;
      for (int i = 0; i < 16; i++)
         if (font[i] == s)
            n = nibble_t'(i);
      return n;
   endfunction

   task automatic fail_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      $display("Errors: %0d before the timeout", errors);
      $display("Finished with errors");
      $finish;
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         errors++;
         $display("ERROR at %0t ns: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_seg(input seg_t got, input seg_t exp, input string what);
      if (got !== exp)
      begin
         errors++;
         $display("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_word(input dal_t exp, input string what);
      dal_t got;
      got = {digit_value(hex3), digit_value(hex2), digit_value(hex1), digit_value(hex0)};
      if (got !== exp)
      begin
         errors++;
         $display("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   // DAL probe on the SDRAM data pins
   task automatic check_dal(input dal_t got, input dal_t exp, input string what);
      if (got !== exp)
      begin
         errors++;
         $display("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp)
      begin
         errors++;
         $display("ERROR at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   // cp_n probe on GPIO0 bits 11:8
   task automatic check_cp(input logic [3:0] exp);
      for (int i = 0; i < 4; i++)
         check_bit(gpio0[8+i], exp[i], "cp_n probe bit");
   endtask

   task automatic model_byte(input addr_t a, input logic [7:0] b);
      if (a[0])
         model[a[`T11_MEM_AW:1]][15:8] = b;   // Odd address, high lane
      else
         model[a[`T11_MEM_AW:1]][7:0] = b;
   endtask

   // Short press, long enough for the two-stage synchronizer
   task automatic press(input int b);
      button[b] = 1'b0;
      repeat (2) @(negedge clk);
      button[b] = 1'b1;
   endtask

   task automatic wait_busy_level(input logic level, input int limit, output int cycles);
      cycles = 0;
      while (led[0] !== level)
      begin
         if (cycles == limit)
            fail_timeout(level ? "busy to rise" : "busy to fall");
         @(negedge clk);
         cycles++;
      end
   endtask

   // Returns the number of cycles busy was high
   task automatic run_op(input op_t op, input logic [7:0] value, output int cycles);
      int n;
      sw = {op, value};
      press(0);
      wait_busy_level(1'b1, 20, n);
      wait_busy_level(1'b0, 40, cycles);
      repeat (2) @(negedge clk);
   endtask

   task automatic run_load(input addr_t a);
      sw = {LOAD, a};
      press(0);
      repeat (4) @(negedge clk);      // Load lands 3 cycles after the press
   endtask

   task automatic step_addr();
      press(1);
      repeat (4) @(negedge clk);
   endtask

   task automatic test_reset();
      int n;
      rst_n = 1'b0;
      repeat (3)
      begin
         @(negedge clk);
         check_bit(led[2], 1'b1, "reset led while button held");
      end
      rst_n = 1'b1;
      n = 0;
      while (led[2] !== 1'b0)
      begin
         if (n == `T11_RESET_HOLD + 20)
            fail_timeout("system reset release");
         @(negedge clk);
         n++;
      end
      // Full hold count from the release to the first low led sample
      check_count(n, `T11_RESET_HOLD + 1, "reset hold cycles");
      check_seg(hex0, font[0], "hex0 after reset");
      check_seg(hex1, font[0], "hex1 after reset");
      check_seg(hex2, font[0], "hex2 after reset");
      check_seg(hex3, font[0], "hex3 after reset");
      check_bit(gpio0[0], 1'b1, "ras_n after reset");
      check_bit(gpio0[1], 1'b1, "cas_n after reset");
      check_bit(gpio0[5], 1'b1, "wb_n[0] after reset");
      check_bit(gpio0[6], 1'b1, "wb_n[1] after reset");
      check_bit(gpio0[12], 1'b1, "vec_n after reset");
      check_bit(led[0], 1'b0, "busy after reset");
      check_bit(led[3], 1'b0, "button led after release");
   endtask

   task automatic test_byte_lanes();
      logic [7:0] lo;
      logic [7:0] hi;
      int         n;
      lo = random_byte();
      hi = random_byte();
      a2 = random_byte();
      a2[0] = 1'b0;                   // Even byte of the word
      run_load(a2);
      run_op(WRITE_BYTE, lo, n);
      model_byte(a2, lo);
      run_load(a2 | 8'd1);
      run_op(WRITE_BYTE, hi, n);
      model_byte(a2 | 8'd1, hi);
      run_load(a2);
      run_op(READ, 8'd0, n);
      check_word({hi, lo}, "word from two byte writes");
   endtask

   task automatic test_address_step();
      addr_t      base;
      addr_t      a;
      logic [7:0] b;
      int         n;
      base = random_byte();
      base[0] = 1'b0;
      a = base | 8'd1;                // High bytes first, odd addresses
      run_load(a);
      for (int i = 0; i < 6; i++)
      begin
         b = random_byte();
         run_op(WRITE_BYTE, b, n);
         model_byte(a, b);
         a = a + 8'd2;
         step_addr();
      end
      a = base;                       // Then the low bytes
      run_load(a);
      for (int i = 0; i < 6; i++)
      begin
         b = random_byte();
         run_op(WRITE_BYTE, b, n);
         model_byte(a, b);
         a = a + 8'd2;
         step_addr();
      end
      a = base;
      run_load(a);
      for (int i = 0; i < 6; i++)
      begin
         run_op(READ, 8'd0, n);
         check_word(model[a[`T11_MEM_AW:1]], "stepped word read");
         a = a + 8'd2;
         step_addr();
      end
   endtask

   task automatic test_interrupts();
      int n;
      irq = 4'b1010;                  // Lines 3 and 1
      n = 0;
      while (led[1] !== 1'b1)
      begin
         if (n == 10)
            fail_timeout("interrupt pending led");
         @(negedge clk);
         n++;
      end
      check_cp(~4'd4);                // Line 3 wins
      run_op(IACK, 8'd0, n);
      check_word(`T11_VEC_BASE + 16'd12, "vector of line 3");
      check_cp(~4'd2);
      check_bit(led[1], 1'b1, "line 1 still pending");
      run_op(IACK, 8'd0, n);
      check_word(`T11_VEC_BASE + 16'd4, "vector of line 1");
      check_bit(led[1], 1'b0, "no interrupt pending");
      check_cp(4'hF);
      irq = 4'b0000;
   endtask

   task automatic test_back_pressure();
      logic [7:0] v1;
      int         n;
      v1 = random_byte();
      run_load(a2);
      sw = {WRITE_BYTE, v1};
      press(0);
      wait_busy_level(1'b1, 20, n);
      sw = {WRITE_BYTE, ~v1};         // Second request, should be dropped
      press(0);
      check_bit(led[0], 1'b1, "busy through second press");
      wait_busy_level(1'b0, 40, n);
      model_byte(a2, v1);
      repeat (8)
      begin
         @(negedge clk);
         check_bit(led[0], 1'b0, "no cycle from dropped press");
      end
      run_op(READ, 8'd0, n);
      check_word(model[a2[`T11_MEM_AW:1]], "read after dropped press");
   endtask

   task automatic test_cycle_length();
      int n;
      run_load(a2);
      sw = {READ, 8'd0};
      press(0);
      wait_busy_level(1'b1, 20, n);
      check_bit(gpio0[0], 1'b0, "ras_n in address phase");
      check_bit(gpio0[1], 1'b1, "cas_n in address phase");
      check_dal(dram_dq, dal_t'(a2), "DAL in address phase");   // Byte address on DAL
      wait_busy_level(1'b0, 40, n);
      check_count(n, `T11_WAIT_STATES + 3, "memory read busy cycles");
      repeat (2) @(negedge clk);
      check_word(model[a2[`T11_MEM_AW:1]], "word of timed read");
   endtask

   initial
   begin
      rst_n  = 1'b0;
      button = 2'b11;                 // Released
      sw     = '0;
      irq    = '0;
      test_reset();
      test_byte_lanes();
      test_address_step();
      test_interrupts();
      test_back_pressure();
      test_cycle_length();
      $display("Errors: %0d", errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

// File: verilog.f
+incdir+verilog
verilog/t11_bus_pkg.sv
verilog/board_pkg.sv
verilog/reset_gen.sv
verilog/switch_console.sv
verilog/bus_cycle.sv
verilog/bus_memory.sv
verilog/intr_encoder.sv
verilog/hex_display.sv
verilog/de0.sv
sim/tb_de0.sv

// File: Bender.yml
package:
  name: t11_de0

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/t11_bus_pkg.sv
      - verilog/board_pkg.sv
      - verilog/reset_gen.sv
      - verilog/switch_console.sv
      - verilog/bus_cycle.sv
      - verilog/bus_memory.sv
      - verilog/intr_encoder.sv
      - verilog/hex_display.sv
      - verilog/de0.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/tb_de0.sv
